// ==== design/csr_pkg.sv ====
////////////////////////////////////////////////////////////
// CSR package
// addresses, privilege levels and exception causes of the
// machine-mode CSR file, plus mstatus and mip bit positions
////////////////////////////////////////////////////////////
`default_nettype none

package csr_pkg;

  localparam int CSR_ADDR_W = 12;

  // implemented CSR addresses, everything else reads as zero
  typedef enum logic [CSR_ADDR_W-1:0] {
    CSR_MSTATUS  = 12'h300,
    CSR_MIE      = 12'h304,
    CSR_MTVEC    = 12'h305,
    CSR_MSCRATCH = 12'h340,
    CSR_MEPC     = 12'h341,
    CSR_MCAUSE   = 12'h342,
    CSR_MTVAL    = 12'h343,
    CSR_MIP      = 12'h344,
    CSR_MCYCLE   = 12'hB00,
    CSR_MINSTRET = 12'hB02,
    CSR_CYCLE    = 12'hC00,
    CSR_INSTRET  = 12'hC02,
    CSR_MHARTID  = 12'hF14
  } csr_addr_e;

  typedef enum logic [1:0] {
    PRIV_USER    = 2'b00,
    PRIV_MACHINE = 2'b11
  } priv_e;

  // causes that matter for mtval selection
  typedef enum logic [3:0] {
    CAUSE_MISALIGNED_FETCH = 4'd0,
    CAUSE_FAULT_FETCH      = 4'd1,
    CAUSE_ILLEGAL_INSTR    = 4'd2,
    CAUSE_BREAKPOINT       = 4'd3,
    CAUSE_MISALIGNED_LOAD  = 4'd4,
    CAUSE_FAULT_LOAD       = 4'd5,
    CAUSE_MISALIGNED_STORE = 4'd6,
    CAUSE_FAULT_STORE      = 4'd7,
    CAUSE_ECALL_U          = 4'd8,
    CAUSE_ECALL_M          = 4'd11
  } cause_e;

  // mstatus field positions, MPP is two bits wide
  localparam int MSTATUS_MIE_BIT  = 3;
  localparam int MSTATUS_MPIE_BIT = 7;
  localparam int MSTATUS_MPP_LSB  = 11;

  // machine interrupt bits shared by mie and mip
  localparam int IRQ_M_SOFT  = 3;
  localparam int IRQ_M_TIMER = 7;
  localparam int IRQ_M_EXT   = 11;

endpackage

`default_nettype wire

// ==== design/csr_trap_if.sv ====
////////////////////////////////////////////////////////////
// trap update bus
// one-cycle update of mcause, mepc and mtval on trap entry
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

interface csr_trap_if #(
  parameter int XLEN = 64
);
  logic            take;
  logic [3:0]      cause;
  logic [XLEN-1:0] epc;
  logic            tval_we;
  logic [XLEN-1:0] tval;

  modport ctrl (output take, cause, epc, tval_we, tval);
  modport bank (input take, cause, epc, tval_we, tval);
endinterface

`default_nettype wire

// ==== design/csr_write_stage.sv ====
////////////////////////////////////////////////////////////
// CSR write stage
// holds a speculative CSR write until its instruction
// commits, a flush cancels it
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module csr_write_stage import csr_pkg::*; #(
  parameter int XLEN = 64
) (
  input  wire logic            clk,
  input  wire logic            reset,
  input  wire logic            wr_en_i,
  input  csr_addr_e            wr_addr_i,
  input  wire logic [XLEN-1:0] wr_data_i,
  input  wire logic            commit_i,
  input  wire logic            flush_i,
  output logic                 commit_we_o,
  output csr_addr_e            commit_addr_o,
  output logic [XLEN-1:0]      commit_data_o
);

  logic valid_q;

  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      commit_addr_o <= wr_addr_i;
      commit_data_o <= wr_data_i;
    end
  end

  // a new write wins over a flush in the same cycle
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      valid_q <= 1'b0;
    end else if (wr_en_i) begin
      valid_q <= 1'b1;
    end else if (flush_i) begin
      valid_q <= 1'b0;
    end
  end

  assign commit_we_o = commit_i & valid_q;

endmodule

`default_nettype wire

// ==== design/csr_counters.sv ====
////////////////////////////////////////////////////////////
// cycle and retired-instruction counters
// a committed CSR write replaces the increment for one cycle
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module csr_counters import csr_pkg::*; #(
  parameter int XLEN         = 64,
  parameter int COMMIT_WIDTH = 4
) (
  input  wire logic                            clk,
  input  wire logic                            reset,
  input  wire logic [$clog2(COMMIT_WIDTH):0]   total_commit_i,
  input  wire logic                            commit_we_i,
  input  csr_addr_e                            commit_addr_i,
  input  wire logic [XLEN-1:0]                 commit_data_i,
  output logic [XLEN-1:0]                      mcycle_o,
  output logic [XLEN-1:0]                      minstret_o
);

  localparam int CNT_W = $clog2(COMMIT_WIDTH) + 1;

  logic [XLEN-1:0] retire_inc;

  assign retire_inc = {{(XLEN-CNT_W){1'b0}}, total_commit_i};

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      mcycle_o   <= '0;
      minstret_o <= '0;
    end else begin
      if (commit_we_i && commit_addr_i == CSR_MCYCLE) begin
        mcycle_o <= commit_data_i;
      end else begin
        mcycle_o <= mcycle_o + 1'b1;
      end
      // up to COMMIT_WIDTH instructions retire per cycle
      if (commit_we_i && commit_addr_i == CSR_MINSTRET) begin
        minstret_o <= commit_data_i;
      end else begin
        minstret_o <= minstret_o + retire_inc;
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/csr_trap_ctrl.sv ====
////////////////////////////////////////////////////////////
// trap controller
// privilege level, mstatus interrupt fields, trap entry,
// mret and the interrupt-pending decision
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module csr_trap_ctrl import csr_pkg::*; #(
  parameter int XLEN = 64
) (
  input  wire logic            clk,
  input  wire logic            reset,
  input  wire logic            exception_i,
  input  wire logic [3:0]      exc_cause_i,
  input  wire logic [XLEN-1:0] exc_pc_i,
  input  wire logic [XLEN-1:0] ld_addr_i,
  input  wire logic [XLEN-1:0] st_addr_i,
  input  wire logic            mret_i,
  input  wire logic            commit_we_i,
  input  csr_addr_e            commit_addr_i,
  input  wire logic [XLEN-1:0] commit_data_i,
  input  wire logic            irq_active_i,
  output logic [XLEN-1:0]      mstatus_o,
  output priv_e                priv_lvl_o,
  output logic                 interrupt_pending_o,
  csr_trap_if.ctrl             trap
);

  logic  mie_q;
  logic  mpie_q;
  priv_e mpp_q;
  logic  mstatus_wr;

  assign mstatus_wr = commit_we_i && (commit_addr_i == CSR_MSTATUS);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      priv_lvl_o <= PRIV_MACHINE;
      mie_q      <= 1'b0;
      mpie_q     <= 1'b0;
      mpp_q      <= PRIV_USER;
    end else begin
      if (exception_i) begin
        mpie_q     <= mie_q;
        mie_q      <= 1'b0;
        mpp_q      <= priv_lvl_o;
        priv_lvl_o <= PRIV_MACHINE;
      end else if (mret_i) begin
        mie_q      <= mpie_q;
        mpie_q     <= 1'b1;
        priv_lvl_o <= mpp_q;
        mpp_q      <= PRIV_USER;
      end
      // software write lands last so it overrides the trap update
      if (mstatus_wr) begin
        mie_q  <= commit_data_i[MSTATUS_MIE_BIT];
        mpie_q <= commit_data_i[MSTATUS_MPIE_BIT];
        // only U and M exist, anything else maps to user
        mpp_q  <= (commit_data_i[MSTATUS_MPP_LSB +: 2] == PRIV_MACHINE) ?
                  PRIV_MACHINE : PRIV_USER;
      end
    end
  end

  always_comb begin
    mstatus_o                          = '0;
    mstatus_o[MSTATUS_MIE_BIT]         = mie_q;
    mstatus_o[MSTATUS_MPIE_BIT]        = mpie_q;
    mstatus_o[MSTATUS_MPP_LSB +: 2]    = mpp_q;
  end

  // trap bus toward the register bank, tval picked by cause
  always_comb begin
    trap.take  = exception_i;
    trap.cause = exc_cause_i;
    trap.epc   = exc_pc_i;
    case (cause_e'(exc_cause_i))
      CAUSE_MISALIGNED_FETCH, CAUSE_FAULT_FETCH: begin
        trap.tval_we = 1'b1;
        trap.tval    = exc_pc_i;
      end
      CAUSE_MISALIGNED_LOAD, CAUSE_FAULT_LOAD: begin
        trap.tval_we = 1'b1;
        trap.tval    = ld_addr_i;
      end
      CAUSE_MISALIGNED_STORE, CAUSE_FAULT_STORE: begin
        trap.tval_we = 1'b1;
        trap.tval    = st_addr_i;
      end
      default: begin
        trap.tval_we = 1'b0;
        trap.tval    = '0;
      end
    endcase
  end

  // user mode cannot mask machine interrupts
  assign interrupt_pending_o = (priv_lvl_o == PRIV_MACHINE) ? (irq_active_i & mie_q) :
                               irq_active_i;

endmodule

`default_nettype wire

// ==== design/csr_bank.sv ====
////////////////////////////////////////////////////////////
// machine CSR bank
// trap registers, mie/mip and the read and check ports
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module csr_bank import csr_pkg::*; #(
  parameter int XLEN = 64
) (
  input  wire logic            clk,
  input  wire logic            reset,
  input  wire logic [XLEN-1:0] start_pc_i,
  input  wire logic [XLEN-1:0] hart_id_i,
  input  wire logic            irq_ext_i,
  input  wire logic            ipi_i,
  input  wire logic            time_irq_i,
  input  wire logic            commit_we_i,
  input  csr_addr_e            commit_addr_i,
  input  wire logic [XLEN-1:0] commit_data_i,
  csr_trap_if.bank             trap,
  input  wire logic [XLEN-1:0] mstatus_i,
  input  wire logic [XLEN-1:0] mcycle_i,
  input  wire logic [XLEN-1:0] minstret_i,
  input  csr_addr_e            rd_addr_i,
  output logic [XLEN-1:0]      rd_data_o,
  input  csr_addr_e            chk_addr_i,
  output logic [XLEN-1:0]      chk_data_o,
  output logic                 irq_active_o,
  output logic [XLEN-1:0]      evec_o,
  output logic [XLEN-1:0]      epc_o
);

  localparam logic [XLEN-1:0] IRQ_MASK =
    XLEN'((1 << IRQ_M_SOFT) | (1 << IRQ_M_TIMER) | (1 << IRQ_M_EXT));

  logic [XLEN-1:0] mtvec_q;
  logic [XLEN-1:0] mepc_q;
  logic [XLEN-1:0] mcause_q;
  logic [XLEN-1:0] mtval_q;
  logic [XLEN-1:0] mscratch_q;
  logic [XLEN-1:0] mie_q;
  logic [XLEN-1:0] mip_sw_q;
  logic [XLEN-1:0] mip;

  function automatic logic [XLEN-1:0] read_csr(input csr_addr_e addr);
    case (addr)
      CSR_MSTATUS:               read_csr = mstatus_i;
      CSR_MIE:                   read_csr = mie_q;
      CSR_MTVEC:                 read_csr = mtvec_q;
      CSR_MSCRATCH:              read_csr = mscratch_q;
      CSR_MEPC:                  read_csr = mepc_q;
      CSR_MCAUSE:                read_csr = mcause_q;
      CSR_MTVAL:                 read_csr = mtval_q;
      CSR_MIP:                   read_csr = mip;
      CSR_MCYCLE, CSR_CYCLE:     read_csr = mcycle_i;
      CSR_MINSTRET, CSR_INSTRET: read_csr = minstret_i;
      CSR_MHARTID:               read_csr = hart_id_i;
      default:                   read_csr = '0;
    endcase
  endfunction

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      mtvec_q    <= start_pc_i;
      mepc_q     <= '0;
      mcause_q   <= '0;
      mtval_q    <= '0;
      mscratch_q <= '0;
      mie_q      <= '0;
      mip_sw_q   <= '0;
    end else begin
      if (trap.take) begin
        mcause_q <= {{(XLEN-4){1'b0}}, trap.cause};
        mepc_q   <= trap.epc;
        if (trap.tval_we) begin
          mtval_q <= trap.tval;
        end
      end
      // a commit to the same register beats the trap value
      if (commit_we_i) begin
        case (commit_addr_i)
          CSR_MTVEC:    mtvec_q    <= {commit_data_i[XLEN-1:2], 1'b0, commit_data_i[0]};
          CSR_MEPC:     mepc_q     <= {commit_data_i[XLEN-1:1], 1'b0};
          CSR_MCAUSE:   mcause_q   <= commit_data_i;
          CSR_MTVAL:    mtval_q    <= commit_data_i;
          CSR_MSCRATCH: mscratch_q <= commit_data_i;
          CSR_MIE:      mie_q      <= commit_data_i & IRQ_MASK;
          CSR_MIP:      mip_sw_q   <= commit_data_i & ~IRQ_MASK;
          default: ;
        endcase
      end
    end
  end

  // interrupt lines own their mip bits
  always_comb begin
    mip              = mip_sw_q;
    mip[IRQ_M_SOFT]  = ipi_i;
    mip[IRQ_M_TIMER] = time_irq_i;
    mip[IRQ_M_EXT]   = irq_ext_i;
  end

  always_comb begin
    rd_data_o  = read_csr(rd_addr_i);
    chk_data_o = read_csr(chk_addr_i);
  end

  assign irq_active_o = |(mie_q & mip);
  assign evec_o       = {mtvec_q[XLEN-1:2], 2'b00};
  assign epc_o        = mepc_q;

endmodule

`default_nettype wire

// ==== design/csr_atomic_check.sv ====
////////////////////////////////////////////////////////////
// read-atomicity check
// flags a CSR that changed after it was read and before the
// reading instruction committed
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module csr_atomic_check import csr_pkg::*; #(
  parameter int XLEN = 64
) (
  input  wire logic            clk,
  input  wire logic            reset,
  input  wire logic            rd_en_i,
  input  csr_addr_e            rd_addr_i,
  input  wire logic [XLEN-1:0] rd_data_i,
  input  wire logic            flush_i,
  input  wire logic            commit_i,
  output csr_addr_e            chk_addr_o,
  input  wire logic [XLEN-1:0] chk_data_i,
  output logic                 atomic_vio_o
);

  logic            valid_q;
  logic [XLEN-1:0] data_q;

  always_ff @(posedge clk) begin
    if (rd_en_i) begin
      chk_addr_o <= rd_addr_i;
      data_q     <= rd_data_i;
    end
  end

  // a new read restarts the checkpoint even during flush or commit
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      valid_q <= 1'b0;
    end else if (rd_en_i) begin
      valid_q <= 1'b1;
    end else if (flush_i || commit_i) begin
      valid_q <= 1'b0;
    end
  end

  assign atomic_vio_o = valid_q && (data_q != chk_data_i);

endmodule

`default_nettype wire

// ==== design/csr_file.sv ====
////////////////////////////////////////////////////////////
// machine-mode CSR file for one RISC-V hart
// staged writes, read-atomicity check, traps and counters
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module csr_file import csr_pkg::*; #(
  parameter int XLEN         = 64,
  parameter int COMMIT_WIDTH = 4
) (
  input  wire logic                          clk,
  input  wire logic                          reset,
  input  wire logic                          flush_i,
  input  wire logic                          wr_en_i,
  input  wire logic [CSR_ADDR_W-1:0]         wr_addr_i,
  input  wire logic [XLEN-1:0]               wr_data_i,
  input  wire logic                          commit_i,
  input  wire logic                          rd_en_i,
  input  wire logic [CSR_ADDR_W-1:0]         rd_addr_i,
  output logic [XLEN-1:0]                    rd_data_o,
  input  wire logic [$clog2(COMMIT_WIDTH):0] total_commit_i,
  input  wire logic                          exception_i,
  input  wire logic [3:0]                    exc_cause_i,
  input  wire logic [XLEN-1:0]               exc_pc_i,
  input  wire logic [XLEN-1:0]               ld_addr_i,
  input  wire logic [XLEN-1:0]               st_addr_i,
  input  wire logic                          mret_i,
  input  wire logic                          irq_ext_i,
  input  wire logic                          ipi_i,
  input  wire logic                          time_irq_i,
  input  wire logic [XLEN-1:0]               hart_id_i,
  input  wire logic [XLEN-1:0]               start_pc_i,
  output logic                               atomic_vio_o,
  output logic                               interrupt_pending_o,
  output logic [XLEN-1:0]                    epc_o,
  output logic [XLEN-1:0]                    evec_o,
  output priv_e                              priv_lvl_o
);

  logic            commit_we;
  csr_addr_e       commit_addr;
  logic [XLEN-1:0] commit_data;
  logic [XLEN-1:0] mstatus;
  logic [XLEN-1:0] mcycle;
  logic [XLEN-1:0] minstret;
  logic            irq_active;
  csr_addr_e       chk_addr;
  logic [XLEN-1:0] chk_data;

  csr_trap_if #(.XLEN(XLEN)) trap_bus ();

  csr_write_stage #(.XLEN(XLEN)) u_stage (
    .clk(clk),
    .reset(reset),
    .wr_en_i(wr_en_i),
    .wr_addr_i(csr_addr_e'(wr_addr_i)),
    .wr_data_i(wr_data_i),
    .commit_i(commit_i),
    .flush_i(flush_i),
    .commit_we_o(commit_we),
    .commit_addr_o(commit_addr),
    .commit_data_o(commit_data)
  );

  csr_counters #(.XLEN(XLEN), .COMMIT_WIDTH(COMMIT_WIDTH)) u_counters (
    .clk(clk),
    .reset(reset),
    .total_commit_i(total_commit_i),
    .commit_we_i(commit_we),
    .commit_addr_i(commit_addr),
    .commit_data_i(commit_data),
    .mcycle_o(mcycle),
    .minstret_o(minstret)
  );

  csr_trap_ctrl #(.XLEN(XLEN)) u_trap_ctrl (
    .clk(clk),
    .reset(reset),
    .exception_i(exception_i),
    .exc_cause_i(exc_cause_i),
    .exc_pc_i(exc_pc_i),
    .ld_addr_i(ld_addr_i),
    .st_addr_i(st_addr_i),
    .mret_i(mret_i),
    .commit_we_i(commit_we),
    .commit_addr_i(commit_addr),
    .commit_data_i(commit_data),
    .irq_active_i(irq_active),
    .mstatus_o(mstatus),
    .priv_lvl_o(priv_lvl_o),
    .interrupt_pending_o(interrupt_pending_o),
    .trap(trap_bus.ctrl)
  );

  csr_bank #(.XLEN(XLEN)) u_bank (
    .clk(clk),
    .reset(reset),
    .start_pc_i(start_pc_i),
    .hart_id_i(hart_id_i),
    .irq_ext_i(irq_ext_i),
    .ipi_i(ipi_i),
    .time_irq_i(time_irq_i),
    .commit_we_i(commit_we),
    .commit_addr_i(commit_addr),
    .commit_data_i(commit_data),
    .trap(trap_bus.bank),
    .mstatus_i(mstatus),
    .mcycle_i(mcycle),
    .minstret_i(minstret),
    .rd_addr_i(csr_addr_e'(rd_addr_i)),
    .rd_data_o(rd_data_o),
    .chk_addr_i(chk_addr),
    .chk_data_o(chk_data),
    .irq_active_o(irq_active),
    .evec_o(evec_o),
    .epc_o(epc_o)
  );

  // checkpoint uses the same read data the instruction sees
  csr_atomic_check #(.XLEN(XLEN)) u_atomic (
    .clk(clk),
    .reset(reset),
    .rd_en_i(rd_en_i),
    .rd_addr_i(csr_addr_e'(rd_addr_i)),
    .rd_data_i(rd_data_o),
    .flush_i(flush_i),
    .commit_i(commit_i),
    .chk_addr_o(chk_addr),
    .chk_data_i(chk_data),
    .atomic_vio_o(atomic_vio_o)
  );

endmodule

`default_nettype wire

// ==== testbench/tb_clkgen.sv ====
////////////////////////////////////////////////////////////
// testbench clock generator, free-running clock
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
  parameter real PERIOD_NS = 8.0
) (
  output logic clk_o
);

  initial clk_o = 1'b0;

  always #(PERIOD_NS / 2.0) clk_o = ~clk_o;

endmodule

`default_nettype wire

// ==== testbench/csr_file_props.sv ====
////////////////////////////////////////////////////////////
// CSR file properties
// reset state, flush clearing the atomicity flag, trap MIE
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module csr_file_props import csr_pkg::*; #(
  parameter int XLEN = 64
) (
  input wire logic                  clk,
  input wire logic                  reset,
  input wire logic                  flush_i,
  input wire logic                  rd_en_i,
  input wire logic                  atomic_vio_o,
  input wire logic                  interrupt_pending_o,
  input wire logic [1:0]            priv_lvl_o,
  input wire logic                  exception_i,
  input wire logic                  commit_we,
  input wire logic [CSR_ADDR_W-1:0] commit_addr,
  input wire logic [XLEN-1:0]       mstatus
);

  a_reset_state: assert property (@(posedge clk)
    reset |-> !interrupt_pending_o && priv_lvl_o == PRIV_MACHINE)
    else $error("interrupt pending or wrong privilege during reset");

  // a new read in the flush cycle restarts the checkpoint
  a_flush_clears: assert property (@(posedge clk) disable iff (reset)
    flush_i && !rd_en_i |=> !atomic_vio_o)
    else $error("atomicity flag high after flush");

  a_trap_mie: assert property (@(posedge clk) disable iff (reset)
    exception_i && !(commit_we && commit_addr == CSR_MSTATUS) |=> !mstatus[MSTATUS_MIE_BIT])
    else $error("MIE still set after trap entry");

endmodule

bind csr_file csr_file_props #(.XLEN(XLEN)) u_props (
  .clk(clk),
  .reset(reset),
  .flush_i(flush_i),
  .rd_en_i(rd_en_i),
  .atomic_vio_o(atomic_vio_o),
  .interrupt_pending_o(interrupt_pending_o),
  .priv_lvl_o(priv_lvl_o),
  .exception_i(exception_i),
  .commit_we(commit_we),
  .commit_addr(commit_addr),
  .mstatus(mstatus)
);

`default_nettype wire

// ==== testbench/csr_file_tb.sv ====
////////////////////////////////////////////////////////////
// CSR file testbench
// shadow register model, read compare process and watchdog
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module csr_file_tb import csr_pkg::*; ();

  localparam int NUM_TESTS = 6;
  localparam int TIMEOUT_CYCLES = 200 * NUM_TESTS;

  logic clk, reset, flush_i, wr_en_i, commit_i, rd_en_i, exception_i, mret_i;
  logic irq_ext_i, ipi_i, time_irq_i, atomic_vio_o, interrupt_pending_o;
  logic [11:0] wr_addr_i, rd_addr_i;
  logic [63:0] wr_data_i, exc_pc_i, ld_addr_i, st_addr_i, hart_id_i, start_pc_i;
  logic [63:0] rd_data_o, epc_o, evec_o, cmp_exp, s0, s1, v, sum;
  logic [2:0] total_commit_i, r;
  logic [3:0] exc_cause_i;
  logic [1:0] priv_lvl_o;
  logic cmp_en;
  string cmp_name;
  integer seed, checks, errors, test_errs;
  // shadow model of the register state
  logic [63:0] sh_mtvec, sh_mepc, sh_mcause, sh_mtval, sh_mscratch, sh_mie, sh_mip_sw;
  logic sh_mie_bit, sh_mpie;
  logic [1:0] sh_mpp, sh_priv;

  tb_clkgen #(.PERIOD_NS(8.0)) clkgen0 (.clk_o(clk));

  csr_file #(.XLEN(64), .COMMIT_WIDTH(4)) dut0 (.*);

  function automatic logic [63:0] ref_mstatus();
    ref_mstatus = 64'(sh_mie_bit) << 3 | 64'(sh_mpie) << 7 | 64'(sh_mpp) << 11;
  endfunction

  function automatic logic [63:0] ref_mip();
    ref_mip = sh_mip_sw | 64'(ipi_i) << 3 | 64'(time_irq_i) << 7 | 64'(irq_ext_i) << 11;
  endfunction

  function automatic logic [63:0] ref_read(input logic [11:0] addr);
    case (addr)
      12'h300: ref_read = ref_mstatus();
      12'h304: ref_read = sh_mie;
      12'h305: ref_read = sh_mtvec;
      12'h340: ref_read = sh_mscratch;
      12'h341: ref_read = sh_mepc;
      12'h342: ref_read = sh_mcause;
      12'h343: ref_read = sh_mtval;
      12'h344: ref_read = ref_mip();
      12'hF14: ref_read = hart_id_i;
      default: ref_read = 64'h0;
    endcase
  endfunction

  function automatic logic ref_pending();
    ref_pending = (|(sh_mie & ref_mip())) && (sh_priv == 2'b00 || sh_mie_bit);
  endfunction

  // compares half a cycle after the read address settles
  always @(negedge clk) begin
    if (cmp_en) begin
      checks = checks + 1;
      if (rd_data_o !== cmp_exp) begin
        errors = errors + 1;
        $display("Fail %s expected %h actual %h", cmp_name, cmp_exp, rd_data_o);
      end
    end
  end

  task automatic check_read(input logic [11:0] addr, input string name);
    @(posedge clk);
    rd_addr_i <= addr;
    cmp_exp <= ref_read(addr);
    cmp_name <= name;
    cmp_en <= 1'b1;
    @(posedge clk);
    cmp_en <= 1'b0;
  endtask

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    checks = checks + 1;
    if (act !== exp) begin
      errors = errors + 1;
      $display("Fail %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic stage_write(input logic [11:0] addr, input logic [63:0] data);
    @(posedge clk);
    wr_en_i <= 1'b1;
    wr_addr_i <= addr;
    wr_data_i <= data;
    @(posedge clk);
    wr_en_i <= 1'b0;
  endtask

  task automatic pulse_commit();
    @(posedge clk);
    commit_i <= 1'b1;
    @(posedge clk);
    commit_i <= 1'b0;
  endtask

  // shadow update by the write masking rules
  task automatic apply_write(input logic [11:0] addr, input logic [63:0] d);
    case (addr)
      12'h300: begin
        sh_mie_bit = d[3];
        sh_mpie = d[7];
        sh_mpp = (d[12:11] == 2'b11) ? 2'b11 : 2'b00;
      end
      12'h304: sh_mie = d & 64'h888;
      12'h305: sh_mtvec = d & ~64'h2;
      12'h340: sh_mscratch = d;
      12'h341: sh_mepc = d & ~64'h1;
      12'h342: sh_mcause = d;
      12'h343: sh_mtval = d;
      12'h344: sh_mip_sw = d & ~64'h888;
      default: ;
    endcase
  endtask

  task automatic commit_write(input logic [11:0] addr, input logic [63:0] d);
    stage_write(addr, d);
    pulse_commit();
    apply_write(addr, d);
  endtask

  task automatic take_trap(input logic [3:0] cause, input logic [63:0] pc);
    @(posedge clk);
    exception_i <= 1'b1;
    exc_cause_i <= cause;
    exc_pc_i <= pc;
    ld_addr_i <= {$random(seed), $random(seed)};
    st_addr_i <= {$random(seed), $random(seed)};
    @(posedge clk);
    exception_i <= 1'b0;
    sh_mpie = sh_mie_bit;
    sh_mie_bit = 1'b0;
    sh_mpp = sh_priv;
    sh_priv = 2'b11;
    sh_mcause = 64'(cause);
    sh_mepc = pc;
    if (cause == 4'd4 || cause == 4'd5) sh_mtval = ld_addr_i;
    if (cause == 4'd6 || cause == 4'd7) sh_mtval = st_addr_i;
    if (cause == 4'd0 || cause == 4'd1) sh_mtval = pc;
  endtask

  task automatic do_mret();
    @(posedge clk);
    mret_i <= 1'b1;
    @(posedge clk);
    mret_i <= 1'b0;
    sh_mie_bit = sh_mpie;
    sh_mpie = 1'b1;
    sh_priv = sh_mpp;
    sh_mpp = 2'b00;
  endtask

  task automatic end_test(input string name);
    $display("test %-12s %s", name, (errors == test_errs) ? "ok" : "with errors");
    test_errs = errors;
  endtask

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("Error: watchdog expired before the tests finished");
    $display("*** FAILED ***");
    $finish;
  end

  initial begin
    seed = 32'h6e4cedc0;
    {checks, errors, test_errs} = '0;
    reset = 1'b1;
    {flush_i, wr_en_i, commit_i, rd_en_i, exception_i, mret_i, cmp_en} = '0;
    {irq_ext_i, ipi_i, time_irq_i} = '0;
    {wr_addr_i, rd_addr_i, wr_data_i, exc_pc_i, ld_addr_i, st_addr_i} = '0;
    {total_commit_i, exc_cause_i} = '0;
    hart_id_i = 64'h5;
    start_pc_i = 64'h0000_0000_8000_0103;
    {sh_mepc, sh_mcause, sh_mtval, sh_mscratch, sh_mie, sh_mip_sw} = '0;
    {sh_mie_bit, sh_mpie, sh_mpp} = '0;
    sh_priv = 2'b11;
    sh_mtvec = start_pc_i;
    repeat (8) @(posedge clk);
    reset <= 1'b0;

    check_read(12'h305, "reset_mtvec");
    check_read(12'h300, "reset_mstatus");
    check_read(12'h340, "reset_mscratch");
    check_read(12'hF14, "mhartid");
    check_read(12'h7C0, "unimplemented");
    @(negedge clk);
    check_value("reset_evec", start_pc_i & ~64'h3, evec_o);
    check_value("reset_priv", 64'h3, 64'(priv_lvl_o));
    check_value("reset_flags", 64'h0, 64'({atomic_vio_o, interrupt_pending_o}));
    end_test("reset");

    v = {$random(seed), $random(seed)};
    stage_write(12'h340, v);
    check_read(12'h340, "mscratch_before_commit");
    pulse_commit();
    apply_write(12'h340, v);
    check_read(12'h340, "mscratch_after_commit");
    stage_write(12'h340, ~v);
    @(posedge clk);
    flush_i <= 1'b1;
    @(posedge clk);
    flush_i <= 1'b0;
    pulse_commit();
    check_read(12'h340, "mscratch_after_flush");
    commit_write(12'h305, 64'h1237);
    check_read(12'h305, "mtvec_masked");
    commit_write(12'h341, 64'h4445);
    check_read(12'h341, "mepc_masked");
    end_test("staged_write");

    // checkpoint and commit in one cycle, so the flag survives the write
    stage_write(12'h340, v ^ 64'h1);
    @(posedge clk);
    rd_en_i <= 1'b1;
    rd_addr_i <= 12'h340;
    commit_i <= 1'b1;
    @(posedge clk);
    {rd_en_i, commit_i} <= 2'b00;
    apply_write(12'h340, v ^ 64'h1);
    @(negedge clk);
    check_value("vio_raised", 64'h1, 64'(atomic_vio_o));
    pulse_commit();
    @(negedge clk);
    check_value("vio_cleared", 64'h0, 64'(atomic_vio_o));
    @(posedge clk);
    rd_en_i <= 1'b1;
    commit_i <= 1'b1;
    @(posedge clk);
    {rd_en_i, commit_i} <= 2'b00;
    @(negedge clk);
    check_value("vio_same_value", 64'h0, 64'(atomic_vio_o));
    // a flush drops a live violation
    stage_write(12'h340, v);
    @(posedge clk);
    rd_en_i <= 1'b1;
    commit_i <= 1'b1;
    @(posedge clk);
    {rd_en_i, commit_i} <= 2'b00;
    apply_write(12'h340, v);
    @(posedge clk);
    flush_i <= 1'b1;
    @(posedge clk);
    flush_i <= 1'b0;
    @(negedge clk);
    check_value("vio_flushed", 64'h0, 64'(atomic_vio_o));
    end_test("atomicity");

    commit_write(12'h300, 64'h8);
    take_trap(4'd4, 64'h2000);
    check_read(12'h342, "load_mcause");
    check_read(12'h341, "load_mepc");
    check_read(12'h343, "load_mtval");
    check_read(12'h300, "load_mstatus");
    take_trap(4'd7, 64'h2010);
    check_read(12'h343, "store_mtval");
    check_read(12'h300, "store_mstatus");
    take_trap(4'd2, 64'h2020);
    check_read(12'h343, "illegal_mtval");
    check_read(12'h342, "illegal_mcause");
    commit_write(12'h300, 64'h80);
    do_mret();
    @(negedge clk);
    check_value("mret_priv", 64'(sh_priv), 64'(priv_lvl_o));
    check_value("mret_epc", sh_mepc, epc_o);
    check_read(12'h300, "mret_mstatus");
    take_trap(4'd8, 64'h3000);
    check_read(12'h300, "ecall_mstatus");
    end_test("trap_mret");

    sum = '0;
    @(posedge clk);
    rd_addr_i <= 12'hB02;
    @(negedge clk);
    s0 = rd_data_o;
    repeat (20) begin
      @(posedge clk);
      r = 3'($unsigned($random(seed)) % 5);
      total_commit_i <= r;
      sum = sum + 64'(r);
    end
    @(posedge clk);
    total_commit_i <= '0;
    @(negedge clk);
    s1 = rd_data_o;
    check_value("minstret_sum", sum, s1 - s0);
    @(posedge clk);
    rd_addr_i <= 12'hC02;
    @(negedge clk);
    check_value("instret_alias", s1, rd_data_o);
    @(posedge clk);
    rd_addr_i <= 12'hB00;
    @(negedge clk);
    s0 = rd_data_o;
    repeat (7) @(posedge clk);
    rd_addr_i <= 12'hC00;
    @(negedge clk);
    check_value("cycle_gap", 64'h7, rd_data_o - s0);
    end_test("counters");

    commit_write(12'h304, 64'hA0);
    @(posedge clk);
    time_irq_i <= 1'b1;
    commit_write(12'h300, 64'h8);
    @(negedge clk);
    check_value("pending_mie_set", 64'(ref_pending()), 64'(interrupt_pending_o));
    commit_write(12'h300, 64'h0);
    @(negedge clk);
    check_value("pending_mie_clear", 64'(ref_pending()), 64'(interrupt_pending_o));
    do_mret();
    @(negedge clk);
    check_value("pending_user", 64'(ref_pending()), 64'(interrupt_pending_o));
    check_read(12'h344, "mip_timer");
    @(posedge clk);
    time_irq_i <= 1'b0;
    @(negedge clk);
    check_value("pending_line_low", 64'h0, 64'(interrupt_pending_o));
    end_test("interrupts");

    $display("tests %0d, checks %0d, errors %0d", NUM_TESTS, checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
design/csr_pkg.sv
design/csr_trap_if.sv
design/csr_write_stage.sv
design/csr_counters.sv
design/csr_trap_ctrl.sv
design/csr_bank.sv
design/csr_atomic_check.sv
design/csr_file.sv
testbench/tb_clkgen.sv
testbench/csr_file_props.sv
testbench/csr_file_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the CSR file testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f verilog.f \
  --top-module csr_file_tb -o sim_csr_file > build.log 2>&1 \
  || { echo "build failed, see build.log"; exit 1; }

./obj_dir/sim_csr_file > sim.log 2>&1
cat sim.log
grep -q '\*\*\* FAILED \*\*\*' sim.log && exit 1 || exit 0
